/* run_sim.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator

BUILD_DIR=obj_dir
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module dcache_tb \
    -f verilog.f --Mdir "$BUILD_DIR" -o dcache_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/dcache_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* tests/dcache_properties.sv */
`timescale 1ns/10ps

module dcache_properties (
    input logic clk,
    input logic rst,
    input logic i_stall,
    input logic i_ar_valid,
    input logic i_ar_ready,
    input logic i_aw_valid
);

    // one burst direction at a time
    ar_aw_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(i_ar_valid && i_aw_valid))
        else $error("ar_valid and aw_valid are high together");

    ar_valid_held: assert property (@(posedge clk) disable iff (rst)
        i_ar_valid && !i_ar_ready |=> i_ar_valid)
        else $error("ar_valid dropped before ar_ready");

    // no stall straight out of reset
    stall_low_after_reset: assert property (@(posedge clk) rst |=> !i_stall)
        else $error("stall is high right after reset");

endmodule

bind dcache_top dcache_properties u_properties (
    .clk        (clk),
    .rst        (rst),
    .i_stall    (o_stall),
    .i_ar_valid (o_ar_valid),
    .i_ar_ready (i_ar_ready),
    .i_aw_valid (o_aw_valid)
);

/* tests/dcache_tb.sv */
`timescale 1ns/10ps

module dcache_tb;

    localparam int MEM_WORDS      = 4096;
    localparam int TIMEOUT_CYCLES = 200;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 i_req_valid;
    dcache_pkg::cpu_req_t i_req;
    logic                 o_stall;
    logic [31:0]          o_rdata;
    logic                 o_ar_valid;
    logic [31:0]          o_ar_addr;
    logic                 i_ar_ready;
    logic                 i_r_valid;
    logic [31:0]          i_r_data;
    logic                 i_r_last;
    logic                 o_r_ready;
    logic                 o_aw_valid;
    logic [31:0]          o_aw_addr;
    logic                 i_aw_ready;
    logic                 o_w_valid;
    logic [31:0]          o_w_data;
    logic                 o_w_last;
    logic                 i_w_ready;
    logic                 i_b_valid;

    integer      seed = 32'h3225e3f9;
    // memory model, and the word values the processor should see
    logic [31:0] mem    [MEM_WORDS];
    logic [31:0] shadow [MEM_WORDS];
    int          wb_count;
    logic [31:0] last_wb_addr;
    // line that the next refill should fetch
    logic [31:0] expected_line;

    always #4 clk = ~clk;

    dcache_top UUT (.*);

    // 32-byte lines, 128 sets, tag from bit 12
    function automatic logic [31:0] make_addr(input int tag, input int index, input int word);
        return 32'((tag << 12) | (index << 5) | (word << 2));
    endfunction

    function automatic logic [31:0] apply_strobe(input logic [31:0] old_word,
                                                 input logic [31:0] new_word,
                                                 input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (new_word & mask) | (old_word & ~mask);
    endfunction

    function automatic int random_delay();
        return int'($random(seed) & 32'h3);
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "mismatch in %s", what);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out at %0t while waiting for %s", $time, what);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // one access from request to result, stall included
    task automatic access_check(input logic wr, input logic [31:0] addr, input logic [3:0] strb,
                                input logic expect_miss, input string what);
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic        missed;
        int          waited;
        wdata         = $random(seed);
        expected_line = {addr[31:5], 5'b0};
        i_req_valid = 1'b1;
        i_req.wr    = wr;
        i_req.addr  = addr;
        i_req.strb  = strb;
        i_req.wdata = wdata;
        @(posedge clk);
        #1;
        missed = o_stall;
        waited = 0;
        while (o_stall) begin
            if (waited == TIMEOUT_CYCLES) begin
                report_timeout({what, ": end of stall"});
            end
            @(posedge clk);
            #1;
            waited++;
        end
        rdata       = o_rdata;
        i_req_valid = 1'b0;
        check_equal(32'(missed), 32'(expect_miss), {what, ": miss"});
        if (wr) begin
            shadow[addr[13:2]] = apply_strobe(shadow[addr[13:2]], wdata, strb);
        end else begin
            check_equal(rdata, shadow[addr[13:2]], {what, ": load data"});
        end
    endtask

    task automatic serve_read_burst();
        logic [31:0] addr;
        int          waited;
        idle_cycles(random_delay());
        addr       = o_ar_addr;
        i_ar_ready = 1'b1;
        @(posedge clk);
        #1;
        i_ar_ready = 1'b0;
        check_equal(addr, expected_line, "refill address");
        for (int beat = 0; beat < 8; beat++) begin
            idle_cycles(random_delay());
            i_r_valid = 1'b1;
            i_r_data  = mem[{addr[13:5], 3'(beat)}];
            i_r_last  = beat == 7;
            waited    = 0;
            while (!o_r_ready) begin
                if (waited == TIMEOUT_CYCLES) begin
                    report_timeout("r_ready");
                end
                @(posedge clk);
                #1;
                waited++;
            end
            @(posedge clk);
            #1;
            i_r_valid = 1'b0;
            i_r_last  = 1'b0;
        end
    endtask

    task automatic serve_write_burst();
        logic [31:0] addr;
        logic [31:0] data;
        logic        last;
        int          waited;
        idle_cycles(random_delay());
        addr       = o_aw_addr;
        i_aw_ready = 1'b1;
        @(posedge clk);
        #1;
        i_aw_ready = 1'b0;
        for (int beat = 0; beat < 8; beat++) begin
            waited = 0;
            while (!o_w_valid) begin
                if (waited == TIMEOUT_CYCLES) begin
                    report_timeout("w_valid");
                end
                @(posedge clk);
                #1;
                waited++;
            end
            idle_cycles(random_delay());
            data      = o_w_data;
            last      = o_w_last;
            i_w_ready = 1'b1;
            @(posedge clk);
            #1;
            i_w_ready = 1'b0;
            check_equal(32'(last), 32'(beat == 7), "w_last");
            mem[{addr[13:5], 3'(beat)}] = data;
        end
        idle_cycles(random_delay());
        i_b_valid = 1'b1;
        @(posedge clk);
        #1;
        i_b_valid    = 1'b0;
        wb_count     = wb_count + 1;
        last_wb_addr = addr;
    endtask

    initial begin : memory_model
        i_ar_ready   = 1'b0;
        i_r_valid    = 1'b0;
        i_r_data     = '0;
        i_r_last     = 1'b0;
        i_aw_ready   = 1'b0;
        i_w_ready    = 1'b0;
        i_b_valid    = 1'b0;
        wb_count     = 0;
        last_wb_addr = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $random(seed);
        end
        forever begin
            @(posedge clk);
            #1;
            if (!rst && o_ar_valid) begin
                serve_read_burst();
            end else if (!rst && o_aw_valid) begin
                serve_write_burst();
            end
        end
    end

    task automatic reset_state_test();
        for (int c = 0; c < 3; c++) begin
            check_equal(32'(o_stall), 32'd0, "o_stall after reset");
            check_equal(32'(o_ar_valid), 32'd0, "o_ar_valid after reset");
            check_equal(32'(o_aw_valid), 32'd0, "o_aw_valid after reset");
            check_equal(32'(o_w_valid), 32'd0, "o_w_valid after reset");
            check_equal(32'(o_r_ready), 32'd0, "o_r_ready after reset");
            idle_cycles(1);
        end
    endtask

    task automatic load_miss_test();
        access_check(1'b0, make_addr(0, 5, 3), 4'h0, 1'b1, "first load");
        access_check(1'b0, make_addr(0, 5, 3), 4'h0, 1'b0, "repeat load");
        access_check(1'b0, make_addr(0, 5, 6), 4'h0, 1'b0, "load in same line");
    endtask

    task automatic store_hit_test();
        access_check(1'b1, make_addr(0, 5, 3), 4'b0110, 1'b0, "partial store hit");
        access_check(1'b0, make_addr(0, 5, 3), 4'h0, 1'b0, "load after store");
    endtask

    // tag 0 dirty and least recent when tag 2 arrives
    task automatic eviction_test();
        logic [31:0] addr;
        int          wb_before;
        access_check(1'b1, make_addr(0, 9, 2), 4'b1100, 1'b1, "store to tag 0");
        access_check(1'b0, make_addr(1, 9, 5), 4'h0, 1'b1, "load tag 1");
        access_check(1'b0, make_addr(1, 9, 1), 4'h0, 1'b0, "touch tag 1");
        wb_before = wb_count;
        access_check(1'b0, make_addr(2, 9, 0), 4'h0, 1'b1, "load tag 2");
        check_equal(32'(wb_count), 32'(wb_before + 1), "write-back count");
        check_equal(last_wb_addr, make_addr(0, 9, 0), "write-back address");
        for (int w = 0; w < 8; w++) begin
            addr = make_addr(0, 9, w);
            check_equal(mem[addr[13:2]], shadow[addr[13:2]], "written-back word");
        end
        access_check(1'b0, make_addr(1, 9, 5), 4'h0, 1'b0, "tag 1 kept");
        access_check(1'b0, make_addr(0, 9, 2), 4'h0, 1'b1, "tag 0 reloaded");
        check_equal(32'(wb_count), 32'(wb_before + 1), "clean victim write-back count");
    endtask

    task automatic store_miss_test();
        access_check(1'b1, make_addr(1, 20, 4), 4'b1001, 1'b1, "store miss");
        access_check(1'b0, make_addr(1, 20, 4), 4'h0, 1'b0, "load merged word");
        access_check(1'b0, make_addr(1, 20, 7), 4'h0, 1'b0, "load refill word");
    endtask

    // one load per cycle over lines filled above
    task automatic hit_stream_test();
        logic [31:0] addrs [6];
        addrs[0] = make_addr(0, 5, 6);
        addrs[1] = make_addr(1, 9, 5);
        addrs[2] = make_addr(1, 20, 4);
        addrs[3] = make_addr(0, 5, 3);
        addrs[4] = make_addr(0, 9, 2);
        addrs[5] = make_addr(1, 20, 7);
        i_req_valid = 1'b1;
        i_req.wr    = 1'b0;
        i_req.strb  = 4'h0;
        i_req.addr  = addrs[0];
        for (int k = 0; k < 6; k++) begin
            @(posedge clk);
            #1;
            check_equal(32'(o_stall), 32'd0, "stall in hit stream");
            check_equal(o_rdata, shadow[addrs[k][13:2]], "hit stream data");
            if (k < 5) begin
                i_req.addr = addrs[k + 1];
            end else begin
                i_req_valid = 1'b0;
            end
        end
    endtask

    initial begin
        rst           = 1'b1;
        i_req_valid   = 1'b0;
        i_req         = '0;
        expected_line = '0;
        repeat (8) begin
            @(posedge clk);
        end
        #1;
        rst = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = mem[i];
        end
        reset_state_test();
        load_miss_test();
        store_hit_test();
        eviction_test();
        store_miss_test();
        hit_stream_test();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* verilog.f */
verilog/dcache_pkg.sv
verilog/dcache_tag_store.sv
verilog/dcache_data_store.sv
verilog/dcache_lookup.sv
verilog/dcache_miss_unit.sv
verilog/dcache_top.sv
tests/dcache_properties.sv
tests/dcache_tb.sv

/* verilog/dcache_data_store.sv */
`timescale 1ns/10ps

module dcache_data_store (
    input  logic                                  clk,
    input  logic                                  i_rd_en,
    input  logic [dcache_pkg::INDEX_BITS-1:0]     i_rd_index,
    input  logic [dcache_pkg::WORD_SEL_BITS-1:0]  i_rd_word,
    output logic [1:0][31:0]                      o_rd_data,
    input  logic                                  i_wr_en,
    input  dcache_pkg::data_wr_t                  i_wr
);

    logic [31:0] mem_q [2][dcache_pkg::NUM_SETS * dcache_pkg::WORDS_PER_LINE];
    logic [dcache_pkg::INDEX_BITS+dcache_pkg::WORD_SEL_BITS-1:0] rd_addr;
    logic [dcache_pkg::INDEX_BITS+dcache_pkg::WORD_SEL_BITS-1:0] wr_addr;
    logic [31:0] wr_word;

    assign rd_addr = {i_rd_index, i_rd_word};
    assign wr_addr = {i_wr.index, i_wr.word};

    // word as it looks after the write, for a read of the same location
    assign wr_word = dcache_pkg::merge_bytes(mem_q[i_wr.way][wr_addr], i_wr.data, i_wr.strb);

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (i_wr.strb[b]) begin
                    mem_q[i_wr.way][wr_addr][8*b +: 8] <= i_wr.data[8*b +: 8];
                end
            end
        end
        if (i_rd_en) begin
            for (int w = 0; w < 2; w++) begin
                if (i_wr_en && int'(i_wr.way) == w && wr_addr == rd_addr) begin
                    o_rd_data[w] <= wr_word;
                end else begin
                    o_rd_data[w] <= mem_q[w][rd_addr];
                end
            end
        end
    end

endmodule

/* verilog/dcache_lookup.sv */
`timescale 1ns/10ps

module dcache_lookup (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_req_valid,
    input  dcache_pkg::cpu_req_t   i_req,
    input  logic                   i_hold,
    input  dcache_pkg::set_meta_t  i_meta,
    input  logic [1:0][31:0]       i_line_data,
    output logic                   o_rd_en,
    output logic                   o_stall_hit,
    output logic [31:0]            o_rdata,
    output logic                   o_meta_wr_en,
    output dcache_pkg::meta_wr_t   o_meta_wr,
    output logic                   o_data_wr_en,
    output dcache_pkg::data_wr_t   o_data_wr,
    output logic                   o_miss_valid,
    output dcache_pkg::miss_req_t  o_miss
);

    logic                                  valid_q;
    dcache_pkg::cpu_req_t                  req_q;
    logic [dcache_pkg::TAG_BITS-1:0]       req_tag;
    logic [1:0]                            way_hit;
    logic                                  hit;
    logic                                  hit_way;
    logic                                  victim;

    assign req_tag = dcache_pkg::addr_tag(req_q.addr);

    assign way_hit[0] = i_meta.way[0].valid && i_meta.way[0].tag == req_tag;
    assign way_hit[1] = i_meta.way[1].valid && i_meta.way[1].tag == req_tag;
    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];

    // an empty way is filled before anything is evicted
    assign victim = !i_meta.way[0].valid ? 1'b0 :
                    !i_meta.way[1].valid ? 1'b1 : i_meta.lru;

    assign o_stall_hit = valid_q && !hit;
    assign o_rd_en     = i_req_valid && !o_stall_hit && !i_hold;
    assign o_rdata     = i_line_data[hit_way];

    assign o_meta_wr_en = valid_q && hit;
    assign o_data_wr_en = valid_q && hit && req_q.wr;
    assign o_miss_valid = o_stall_hit;

    always_comb begin
        o_meta_wr.index      = dcache_pkg::addr_index(req_q.addr);
        o_meta_wr.way        = hit_way;
        o_meta_wr.meta.valid = 1'b1;
        o_meta_wr.meta.dirty = i_meta.way[hit_way].dirty || req_q.wr;
        o_meta_wr.meta.tag   = req_tag;
        o_meta_wr.lru        = ~hit_way;

        o_data_wr.way   = hit_way;
        o_data_wr.index = dcache_pkg::addr_index(req_q.addr);
        o_data_wr.word  = dcache_pkg::addr_word(req_q.addr);
        o_data_wr.strb  = req_q.strb;
        o_data_wr.data  = req_q.wdata;

        o_miss.req          = req_q;
        o_miss.way          = victim;
        o_miss.victim_tag   = i_meta.way[victim].tag;
        o_miss.victim_dirty = i_meta.way[victim].valid && i_meta.way[victim].dirty;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= o_rd_en;
        end
    end

    // stores read the set in the same edge
    always_ff @(posedge clk) begin
        if (o_rd_en) begin
            req_q <= i_req;
        end
    end

endmodule

/* verilog/dcache_miss_unit.sv */
`timescale 1ns/10ps

module dcache_miss_unit (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  i_miss_valid,
    input  dcache_pkg::miss_req_t                 i_miss,
    output logic                                  o_ar_valid,
    output logic [31:0]                           o_ar_addr,
    input  logic                                  i_ar_ready,
    input  logic                                  i_r_valid,
    input  logic [31:0]                           i_r_data,
    input  logic                                  i_r_last,
    output logic                                  o_r_ready,
    output logic                                  o_aw_valid,
    output logic [31:0]                           o_aw_addr,
    input  logic                                  i_aw_ready,
    output logic                                  o_w_valid,
    output logic [31:0]                           o_w_data,
    output logic                                  o_w_last,
    input  logic                                  i_w_ready,
    input  logic                                  i_b_valid,
    input  logic [1:0][31:0]                      i_line_data,
    output logic                                  o_rd_en,
    output logic [dcache_pkg::INDEX_BITS-1:0]     o_rd_index,
    output logic [dcache_pkg::WORD_SEL_BITS-1:0]  o_rd_word,
    output logic                                  o_data_wr_en,
    output dcache_pkg::data_wr_t                  o_data_wr,
    output logic                                  o_meta_wr_en,
    output dcache_pkg::meta_wr_t                  o_meta_wr,
    output logic                                  o_busy,
    output logic                                  o_done,
    output logic [31:0]                           o_rdata
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITE_BACK,
        S_WAIT_RESP,
        S_REFILL
    } state_t;

    state_t                                  state;
    dcache_pkg::miss_req_t                   miss_q;
    logic [dcache_pkg::WORD_SEL_BITS-1:0]    beat;
    logic [dcache_pkg::WORD_SEL_BITS-1:0]    req_word;
    logic [dcache_pkg::INDEX_BITS-1:0]       req_index;
    logic                                    r_fire;
    logic [31:0]                             fill_word;

    assign req_index = dcache_pkg::addr_index(miss_q.req.addr);
    assign req_word  = dcache_pkg::addr_word(miss_q.req.addr);
    assign r_fire    = o_r_ready && i_r_valid;

    // store miss merges into the refill word
    assign fill_word = (miss_q.req.wr && beat == req_word) ?
        dcache_pkg::merge_bytes(i_r_data, miss_q.req.wdata, miss_q.req.strb) : i_r_data;

    assign o_busy    = state != S_IDLE;
    assign o_ar_addr = {miss_q.req.addr[31:dcache_pkg::LINE_BITS], {dcache_pkg::LINE_BITS{1'b0}}};
    assign o_aw_addr = {miss_q.victim_tag, req_index, {dcache_pkg::LINE_BITS{1'b0}}};
    assign o_w_data  = i_line_data[miss_q.way];
    assign o_w_last  = o_w_valid && (&beat);

    // victim words stream out one read ahead of the w channel
    assign o_rd_en    = state == S_WRITE_BACK && (!o_w_valid || (i_w_ready && !o_w_last));
    assign o_rd_index = req_index;
    assign o_rd_word  = o_w_valid ? beat + 1'b1 : '0;

    assign o_data_wr_en = r_fire;
    assign o_meta_wr_en = r_fire && i_r_last;

    always_comb begin
        o_data_wr.way   = miss_q.way;
        o_data_wr.index = req_index;
        o_data_wr.word  = beat;
        o_data_wr.strb  = 4'hf;
        o_data_wr.data  = fill_word;

        o_meta_wr.index      = req_index;
        o_meta_wr.way        = miss_q.way;
        o_meta_wr.meta.valid = 1'b1;
        o_meta_wr.meta.dirty = miss_q.req.wr;
        o_meta_wr.meta.tag   = dcache_pkg::addr_tag(miss_q.req.addr);
        o_meta_wr.lru        = ~miss_q.way;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            beat       <= '0;
            o_ar_valid <= 1'b0;
            o_r_ready  <= 1'b0;
            o_aw_valid <= 1'b0;
            o_w_valid  <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (o_aw_valid && i_aw_ready) begin
                o_aw_valid <= 1'b0;
            end
            case (state)
                S_IDLE: begin
                    if (i_miss_valid) begin
                        beat <= '0;
                        if (i_miss.victim_dirty) begin
                            state      <= S_WRITE_BACK;
                            o_aw_valid <= 1'b1;
                        end else begin
                            state      <= S_REFILL;
                            o_ar_valid <= 1'b1;
                        end
                    end
                end
                S_WRITE_BACK: begin
                    if (!o_w_valid) begin
                        // word 0 comes out of the store now
                        o_w_valid <= 1'b1;
                    end else if (i_w_ready) begin
                        if (o_w_last) begin
                            o_w_valid <= 1'b0;
                            state     <= S_WAIT_RESP;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
                S_WAIT_RESP: begin
                    if (i_b_valid) begin
                        beat       <= '0;
                        o_ar_valid <= 1'b1;
                        state      <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (o_ar_valid && i_ar_ready) begin
                        o_ar_valid <= 1'b0;
                        o_r_ready  <= 1'b1;
                    end
                    if (r_fire) begin
                        beat <= beat + 1'b1;
                        if (i_r_last) begin
                            o_r_ready <= 1'b0;
                            o_done    <= 1'b1;
                            state     <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && i_miss_valid) begin
            miss_q <= i_miss;
        end
        if (r_fire && beat == req_word) begin
            o_rdata <= fill_word;
        end
    end

endmodule

/* verilog/dcache_pkg.sv */
package dcache_pkg;

    // 32-byte lines, 128 sets, two ways
    localparam int LINE_BITS      = 5;
    localparam int INDEX_BITS     = 7;
    localparam int TAG_BITS       = 32 - INDEX_BITS - LINE_BITS;
    localparam int WORDS_PER_LINE = 1 << (LINE_BITS - 2);
    localparam int WORD_SEL_BITS  = LINE_BITS - 2;
    localparam int NUM_SETS       = 1 << INDEX_BITS;

    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [TAG_BITS-1:0] tag;
    } way_meta_t;

    // lru names the way to evict next
    typedef struct packed {
        logic                lru;
        way_meta_t [1:0]     way;
    } set_meta_t;

    typedef struct packed {
        cpu_req_t            req;
        logic                way;
        logic [TAG_BITS-1:0] victim_tag;
        logic                victim_dirty;
    } miss_req_t;

    typedef struct packed {
        logic                     way;
        logic [INDEX_BITS-1:0]    index;
        logic [WORD_SEL_BITS-1:0] word;
        logic [3:0]               strb;
        logic [31:0]              data;
    } data_wr_t;

    typedef struct packed {
        logic [INDEX_BITS-1:0] index;
        logic                  way;
        way_meta_t             meta;
        logic                  lru;
    } meta_wr_t;

    function automatic logic [TAG_BITS-1:0] addr_tag(input logic [31:0] addr);
        return addr[31 -: TAG_BITS];
    endfunction

    function automatic logic [INDEX_BITS-1:0] addr_index(input logic [31:0] addr);
        return addr[LINE_BITS +: INDEX_BITS];
    endfunction

    function automatic logic [WORD_SEL_BITS-1:0] addr_word(input logic [31:0] addr);
        return addr[2 +: WORD_SEL_BITS];
    endfunction

    // bytes set in strb come from new_data
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_data,
                                                input logic [31:0] new_data,
                                                input logic [3:0]  strb);
        logic [31:0] result;
        for (int b = 0; b < 4; b++) begin
            result[8*b +: 8] = strb[b] ? new_data[8*b +: 8] : old_data[8*b +: 8];
        end
        return result;
    endfunction

endpackage

/* verilog/dcache_tag_store.sv */
`timescale 1ns/10ps

module dcache_tag_store (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  i_rd_en,
    input  logic [dcache_pkg::INDEX_BITS-1:0]     i_rd_index,
    output dcache_pkg::set_meta_t                 o_rd_meta,
    input  logic                                  i_wr_en,
    input  dcache_pkg::meta_wr_t                  i_wr
);

    logic [1:0]                        valid_q [dcache_pkg::NUM_SETS];
    logic [1:0]                        dirty_q [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::TAG_BITS-1:0]   tag_q   [2][dcache_pkg::NUM_SETS];
    logic                              lru_q   [dcache_pkg::NUM_SETS];
    dcache_pkg::set_meta_t             cur_meta;

    // current set contents, with a same-cycle write forwarded
    always_comb begin
        cur_meta.lru = lru_q[i_rd_index];
        for (int w = 0; w < 2; w++) begin
            cur_meta.way[w].valid = valid_q[i_rd_index][w];
            cur_meta.way[w].dirty = dirty_q[i_rd_index][w];
            cur_meta.way[w].tag   = tag_q[w][i_rd_index];
        end
        if (i_wr_en && i_wr.index == i_rd_index) begin
            cur_meta.lru            = i_wr.lru;
            cur_meta.way[i_wr.way]  = i_wr.meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (i_wr_en) begin
            valid_q[i_wr.index][i_wr.way] <= i_wr.meta.valid;
            dirty_q[i_wr.index][i_wr.way] <= i_wr.meta.dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_q[i_wr.way][i_wr.index] <= i_wr.meta.tag;
            lru_q[i_wr.index]           <= i_wr.lru;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_meta <= cur_meta;
        end
    end

endmodule

/* verilog/dcache_top.sv */
`timescale 1ns/10ps

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_req_valid,
    input  dcache_pkg::cpu_req_t  i_req,
    output logic                  o_stall,
    output logic [31:0]           o_rdata,
    output logic                  o_ar_valid,
    output logic [31:0]           o_ar_addr,
    input  logic                  i_ar_ready,
    input  logic                  i_r_valid,
    input  logic [31:0]           i_r_data,
    input  logic                  i_r_last,
    output logic                  o_r_ready,
    output logic                  o_aw_valid,
    output logic [31:0]           o_aw_addr,
    input  logic                  i_aw_ready,
    output logic                  o_w_valid,
    output logic [31:0]           o_w_data,
    output logic                  o_w_last,
    input  logic                  i_w_ready,
    input  logic                  i_b_valid
);

    dcache_pkg::set_meta_t                 rd_meta;
    logic [1:0][31:0]                      line_data;
    logic                                  lk_rd_en;
    logic                                  stall_hit;
    logic [31:0]                           lk_rdata;
    logic                                  lk_meta_wr_en;
    dcache_pkg::meta_wr_t                  lk_meta_wr;
    logic                                  lk_data_wr_en;
    dcache_pkg::data_wr_t                  lk_data_wr;
    logic                                  miss_valid;
    dcache_pkg::miss_req_t                 miss;
    logic                                  mu_rd_en;
    logic [dcache_pkg::INDEX_BITS-1:0]     mu_rd_index;
    logic [dcache_pkg::WORD_SEL_BITS-1:0]  mu_rd_word;
    logic                                  mu_data_wr_en;
    dcache_pkg::data_wr_t                  mu_data_wr;
    logic                                  mu_meta_wr_en;
    dcache_pkg::meta_wr_t                  mu_meta_wr;
    logic                                  busy;
    logic                                  done;
    logic [31:0]                           mu_rdata;

    assign o_stall = stall_hit || busy;
    assign o_rdata = done ? mu_rdata : lk_rdata;

    dcache_lookup u_lookup (
        .clk          (clk),
        .rst          (rst),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .i_hold       (busy),
        .i_meta       (rd_meta),
        .i_line_data  (line_data),
        .o_rd_en      (lk_rd_en),
        .o_stall_hit  (stall_hit),
        .o_rdata      (lk_rdata),
        .o_meta_wr_en (lk_meta_wr_en),
        .o_meta_wr    (lk_meta_wr),
        .o_data_wr_en (lk_data_wr_en),
        .o_data_wr    (lk_data_wr),
        .o_miss_valid (miss_valid),
        .o_miss       (miss)
    );

    dcache_miss_unit u_miss_unit (
        .clk          (clk),
        .rst          (rst),
        .i_miss_valid (miss_valid),
        .i_miss       (miss),
        .o_ar_valid   (o_ar_valid),
        .o_ar_addr    (o_ar_addr),
        .i_ar_ready   (i_ar_ready),
        .i_r_valid    (i_r_valid),
        .i_r_data     (i_r_data),
        .i_r_last     (i_r_last),
        .o_r_ready    (o_r_ready),
        .o_aw_valid   (o_aw_valid),
        .o_aw_addr    (o_aw_addr),
        .i_aw_ready   (i_aw_ready),
        .o_w_valid    (o_w_valid),
        .o_w_data     (o_w_data),
        .o_w_last     (o_w_last),
        .i_w_ready    (i_w_ready),
        .i_b_valid    (i_b_valid),
        .i_line_data  (line_data),
        .o_rd_en      (mu_rd_en),
        .o_rd_index   (mu_rd_index),
        .o_rd_word    (mu_rd_word),
        .o_data_wr_en (mu_data_wr_en),
        .o_data_wr    (mu_data_wr),
        .o_meta_wr_en (mu_meta_wr_en),
        .o_meta_wr    (mu_meta_wr),
        .o_busy       (busy),
        .o_done       (done),
        .o_rdata      (mu_rdata)
    );

    dcache_tag_store u_tag_store (
        .clk        (clk),
        .rst        (rst),
        .i_rd_en    (lk_rd_en),
        .i_rd_index (dcache_pkg::addr_index(i_req.addr)),
        .o_rd_meta  (rd_meta),
        .i_wr_en    (lk_meta_wr_en || mu_meta_wr_en),
        .i_wr       (busy ? mu_meta_wr : lk_meta_wr)
    );

    // miss unit owns the read port while it runs
    dcache_data_store u_data_store (
        .clk        (clk),
        .i_rd_en    (busy ? mu_rd_en : lk_rd_en),
        .i_rd_index (busy ? mu_rd_index : dcache_pkg::addr_index(i_req.addr)),
        .i_rd_word  (busy ? mu_rd_word : dcache_pkg::addr_word(i_req.addr)),
        .o_rd_data  (line_data),
        .i_wr_en    (lk_data_wr_en || mu_data_wr_en),
        .i_wr       (busy ? mu_data_wr : lk_data_wr)
    );

endmodule
